/* sources.f */
hdl/dcache_pkg.sv
hdl/line_store.sv
hdl/load_align.sv
hdl/miss_controller.sv
hdl/dcache_top.sv
verif/tb_clock.sv
verif/mem_model.sv
verif/dcache_tb.sv

/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/dcache_tb.sv */
// data cache testbench with random loads and stores checked per response against a shadow memory
`timescale 1ns/1ps

module dcache_tb;

    localparam int num_reqs   = 600;
    localparam int max_cycles = num_reqs * 12;
    localparam int mem_size   = 1024;

    logic                          clk;
    logic                          reset;
    logic                          req_valid;
    logic                          req_ready;
    dcache_pkg::cache_req_t        req;
    logic                          rsp_valid;
    logic [dcache_pkg::data_w-1:0] rsp_data;
    logic                          mem_req_valid;
    logic                          mem_req_ready;
    dcache_pkg::mem_req_t          mem_req;
    logic                          mem_rsp_valid;
    logic [dcache_pkg::data_w-1:0] mem_rdata;

    logic [7:0]                    shadow [mem_size];
    logic [dcache_pkg::data_w-1:0] expected_q [$];
    logic [15:0]                   lfsr;
    int                            cycles = 0;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    mem_model #(.seed(16'd38972)) u_mem (
        .clk           (clk),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata)
    );

    dcache_top UUT (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata)
    );

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    function automatic int size_bytes(input dcache_pkg::access_size_e size);
        if (size == dcache_pkg::size_byte) begin
            return 1;
        end
        return (size == dcache_pkg::size_half) ? 2 : 4;
    endfunction

    // little-endian read of the shadow sign-extended from its top byte
    function automatic logic [dcache_pkg::data_w-1:0] expected_load(
        input logic [dcache_pkg::addr_w-1:0] addr,
        input dcache_pkg::access_size_e      size
    );
        logic [31:0] value;
        logic [9:0]  a;
        logic        sign;
        value = '0;
        sign  = 1'b0;
        for (int b = 0; b < 4; b++) begin
            a = addr[9:0] + 10'(b);
            if (b < size_bytes(size)) begin
                value[8*b +: 8] = shadow[a];
                sign            = shadow[a][7];
            end else begin
                value[8*b +: 8] = {8{sign}};
            end
        end
        return value;
    endfunction

    task automatic apply_store(input dcache_pkg::cache_req_t r);
        logic [9:0] a;
        for (int b = 0; b < size_bytes(r.size); b++) begin
            a         = r.addr[9:0] + 10'(b);
            shadow[a] = r.wdata[8*b +: 8];
        end
    endtask

    task automatic check_load_data(input string name, input logic [dcache_pkg::data_w-1:0] actual,
                                   input logic [dcache_pkg::data_w-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "response data mismatch");
        end
    endtask

    task automatic check_mem_byte(input string name, input logic [7:0] actual,
                                  input logic [7:0] expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "memory byte mismatch");
        end
    endtask

    initial begin
        dcache_pkg::cache_req_t item;
        logic [31:0]            r;
        req_valid = 1'b0;
        req       = '0;
        lfsr      = 16'd38972;
        @(negedge reset);
        for (int i = 0; i < mem_size; i++) begin
            shadow[i] = u_mem.mem_bytes[i];
        end
        for (int n = 0; n < num_reqs; n++) begin
            draw_bits(1, r);
            item.op = r[0] ? dcache_pkg::op_store : dcache_pkg::op_load;
            draw_bits(2, r);
            item.size = (r[1:0] == 2'b00) ? dcache_pkg::size_byte :
                        (r[1:0] == 2'b01) ? dcache_pkg::size_half : dcache_pkg::size_word;
            // small window so lines alias and cross index 15 to 0
            draw_bits(8, r);
            item.addr = {12'b0, r[7:0]};
            draw_bits(32, r);
            item.wdata = r;
            req        = item;
            req_valid  = 1'b1;
            while (!req_ready) @(negedge clk);
            // taken at the coming rising edge
            if (item.op == dcache_pkg::op_store) begin
                apply_store(item);
                expected_q.push_back('0);
            end else begin
                expected_q.push_back(expected_load(item.addr, item.size));
            end
            @(negedge clk);
            req_valid = 1'b0;
            draw_bits(1, r);
            if (r[0]) begin
                @(negedge clk);
            end
        end
        while (expected_q.size() != 0 || !req_ready) @(negedge clk);
        for (int i = 0; i < mem_size; i++) begin
            check_mem_byte($sformatf("mem byte %0d", i), u_mem.mem_bytes[i], shadow[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            if (expected_q.size() == 0) begin
                $display("a response arrived at time %0t with no request outstanding", $time);
                $display("Finished with errors");
                $fatal(1, "unexpected response");
            end else begin
                check_load_data("rsp_data", rsp_data, expected_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

endmodule

/* verif/mem_model.sv */
// testbench memory behind the cache's memory port, with random stalls and read latency
`timescale 1ns/1ps

module mem_model #(
    parameter logic [15:0] seed = 16'd38972
) (
    input  logic                          clk,
    input  logic                          mem_req_valid,
    output logic                          mem_req_ready,
    input  dcache_pkg::mem_req_t          mem_req,
    output logic                          mem_rsp_valid,
    output logic [dcache_pkg::data_w-1:0] mem_rdata
);

    logic [7:0]  mem_bytes [1024];
    logic [15:0] lfsr = seed;
    logic [9:0]  rd_addr;
    logic [1:0]  wait_cnt;
    logic [1:0]  next_delay;
    logic        rd_pending;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[6:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    initial begin
        logic [15:0] s;
        logic [7:0]  r;
        s             = seed;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        rd_pending    = 1'b0;
        rd_addr       = '0;
        wait_cnt      = '0;
        next_delay    = '0;
        // random bytes folded with the address so aliased lines differ
        for (int a = 0; a < 1024; a++) begin
            r = '0;
            for (int i = 0; i < 8; i++) begin
                r = {r[6:0], s[0]};
                s = lfsr_step(s);
            end
            mem_bytes[10'(a)] = r ^ 8'(a) ^ 8'(a >> 8);
        end
    end

    always @(posedge clk) begin
        if (mem_rsp_valid) begin
            rd_pending = 1'b0;
        end else if (rd_pending && wait_cnt != 2'd0) begin
            wait_cnt = wait_cnt - 2'd1;
        end
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.strobe[b]) begin
                        mem_bytes[{mem_req.addr[9:2], 2'(b)}] = mem_req.wdata[8*b +: 8];
                    end
                end
            end else begin
                rd_addr    = mem_req.addr[9:0];
                wait_cnt   = next_delay;
                rd_pending = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        logic [7:0] r;
        draw_bits(2, r);
        // ready about three cycles in four
        mem_req_ready = |r[1:0];
        draw_bits(2, r);
        next_delay = r[1:0];
        mem_rsp_valid = rd_pending && (wait_cnt == 2'd0);
        if (mem_rsp_valid) begin
            mem_rdata = {mem_bytes[{rd_addr[9:2], 2'd3}], mem_bytes[{rd_addr[9:2], 2'd2}],
                         mem_bytes[{rd_addr[9:2], 2'd1}], mem_bytes[{rd_addr[9:2], 2'd0}]};
        end
    end

endmodule

/* verif/tb_clock.sv */
// testbench clock and reset, 100 ns period with reset held for two cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        // release on a falling edge like every other input
        @(negedge clk);
        reset = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

/* hdl/dcache_top.sv */
// data cache top: joins line storage, load alignment and the miss controller
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  dcache_pkg::cache_req_t        req,
    output logic                          rsp_valid,
    output logic [dcache_pkg::data_w-1:0] rsp_data,
    output logic                          mem_req_valid,
    input  logic                          mem_req_ready,
    output dcache_pkg::mem_req_t          mem_req,
    input  logic                          mem_rsp_valid,
    input  logic [dcache_pkg::data_w-1:0] mem_rdata
);

    logic [dcache_pkg::addr_w-1:0] lookup_addr;
    dcache_pkg::line_span_t        span;
    logic [dcache_pkg::data_w-1:0] first_word;
    logic [dcache_pkg::data_w-1:0] second_word;
    logic [dcache_pkg::data_w-1:0] load_data;
    logic                          fill_en;
    logic [dcache_pkg::addr_w-1:0] fill_addr;
    logic [dcache_pkg::data_w-1:0] fill_data;
    logic                          store_en;
    dcache_pkg::access_size_e      store_size;
    logic [dcache_pkg::data_w-1:0] store_data;

    line_store u_line_store (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .span        (span),
        .first_word  (first_word),
        .second_word (second_word),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .store_en    (store_en),
        .store_size  (store_size),
        .store_data  (store_data)
    );

    // store_size carries the size of the active access, loads included
    load_align u_load_align (
        .lookup_addr (lookup_addr),
        .size        (store_size),
        .first_word  (first_word),
        .second_word (second_word),
        .load_data   (load_data)
    );

    miss_controller u_miss_controller (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .span          (span),
        .load_data     (load_data),
        .lookup_addr   (lookup_addr),
        .fill_en       (fill_en),
        .fill_addr     (fill_addr),
        .fill_data     (fill_data),
        .store_en      (store_en),
        .store_size    (store_size),
        .store_data    (store_data)
    );

endmodule

/* hdl/miss_controller.sv */
// miss controller: accepts requests, sequences refills and write-through, registers the response
`timescale 1ns/1ps

module miss_controller (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  dcache_pkg::cache_req_t        req,
    output logic                          rsp_valid,
    output logic [dcache_pkg::data_w-1:0] rsp_data,
    output logic                          mem_req_valid,
    input  logic                          mem_req_ready,
    output dcache_pkg::mem_req_t          mem_req,
    input  logic                          mem_rsp_valid,
    input  logic [dcache_pkg::data_w-1:0] mem_rdata,
    input  dcache_pkg::line_span_t        span,
    input  logic [dcache_pkg::data_w-1:0] load_data,
    output logic [dcache_pkg::addr_w-1:0] lookup_addr,
    output logic                          fill_en,
    output logic [dcache_pkg::addr_w-1:0] fill_addr,
    output logic [dcache_pkg::data_w-1:0] fill_data,
    output logic                          store_en,
    output dcache_pkg::access_size_e      store_size,
    output logic [dcache_pkg::data_w-1:0] store_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_first,
        st_fetch_second,
        st_write_first,
        st_write_second,
        st_respond
    } state_e;

    state_e                        state;
    dcache_pkg::cache_req_t        cur;
    logic                          read_pending;
    logic                          busy;
    logic                          accept;
    logic                          all_hit;
    logic                          fetching;
    logic                          mem_fire;
    logic [dcache_pkg::addr_w-1:0] first_word_addr;
    logic [dcache_pkg::addr_w-1:0] second_word_addr;
    dcache_pkg::store_lanes_t      lanes;

    assign busy      = (state != st_idle);
    // held low while the response is out
    assign req_ready = !busy && !rsp_valid;
    assign accept    = req_valid && req_ready;

    // lookup follows the input while idle so a hit is seen in the accept cycle
    assign lookup_addr = busy ? cur.addr : req.addr;
    assign store_size  = busy ? cur.size : req.size;
    assign store_data  = cur.wdata;

    assign all_hit = span.first_hit && (!span.second_needed || span.second_hit);

    assign first_word_addr  = {cur.addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w],
                               {dcache_pkg::offset_w{1'b0}}};
    assign second_word_addr = first_word_addr + dcache_pkg::word_step;

    assign lanes = dcache_pkg::store_lanes(cur.addr[dcache_pkg::offset_w-1:0],
                                           cur.size, cur.wdata);

    assign fetching = (state == st_fetch_first) || (state == st_fetch_second);

    always_comb begin
        mem_req       = '0;
        mem_req_valid = 1'b0;
        case (state)
            st_fetch_first: begin
                mem_req_valid = !read_pending;
                mem_req.addr  = first_word_addr;
            end
            st_fetch_second: begin
                mem_req_valid = !read_pending;
                mem_req.addr  = second_word_addr;
            end
            st_write_first: begin
                mem_req_valid  = 1'b1;
                mem_req.write  = 1'b1;
                mem_req.addr   = first_word_addr;
                mem_req.wdata  = lanes.data[dcache_pkg::data_w-1:0];
                mem_req.strobe = lanes.strobe[3:0];
            end
            st_write_second: begin
                mem_req_valid  = 1'b1;
                mem_req.write  = 1'b1;
                mem_req.addr   = second_word_addr;
                mem_req.wdata  = lanes.data[2*dcache_pkg::data_w-1:dcache_pkg::data_w];
                mem_req.strobe = lanes.strobe[7:4];
            end
            default: begin
            end
        endcase
    end

    assign mem_fire  = mem_req_valid && mem_req_ready;
    assign fill_en   = fetching && mem_rsp_valid;
    assign fill_addr = (state == st_fetch_second) ? second_word_addr : first_word_addr;
    assign fill_data = mem_rdata;

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            read_pending <= 1'b0;
            store_en     <= 1'b0;
            rsp_valid    <= 1'b0;
        end else begin
            store_en  <= 1'b0;
            rsp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (req.op == dcache_pkg::op_store) begin
                            state    <= st_write_first;
                            store_en <= 1'b1;
                        end else if (all_hit) begin
                            rsp_valid <= 1'b1;
                        end else if (!span.first_hit) begin
                            state <= st_fetch_first;
                        end else begin
                            state <= st_fetch_second;
                        end
                    end
                end
                st_fetch_first, st_fetch_second: begin
                    if (mem_fire) begin
                        read_pending <= 1'b1;
                    end else if (mem_rsp_valid) begin
                        read_pending <= 1'b0;
                        // first line lands now, second may still be missing
                        if (state == st_fetch_first && span.second_needed && !span.second_hit) begin
                            state <= st_fetch_second;
                        end else begin
                            state <= st_respond;
                        end
                    end
                end
                st_write_first: begin
                    if (mem_fire) begin
                        state <= (|lanes.strobe[7:4]) ? st_write_second : st_respond;
                    end
                end
                st_write_second: begin
                    if (mem_fire) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    rsp_valid <= 1'b1;
                    state     <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // lines are settled by respond, so load_data is read there
    always_ff @(posedge clk) begin
        if (accept && req.op == dcache_pkg::op_load && all_hit) begin
            rsp_data <= load_data;
        end else if (state == st_respond) begin
            rsp_data <= (cur.op == dcache_pkg::op_load) ? load_data : '0;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("miss_controller: memory request changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> fetching && read_pending)
        else $error("miss_controller: read data with no read outstanding");

endmodule

/* hdl/load_align.sv */
// load alignment that extracts the addressed bytes from two adjacent lines and sign-extends them
`timescale 1ns/1ps

module load_align (
    input  logic [dcache_pkg::addr_w-1:0] lookup_addr,
    input  dcache_pkg::access_size_e      size,
    input  logic [dcache_pkg::data_w-1:0] first_word,
    input  logic [dcache_pkg::data_w-1:0] second_word,
    output logic [dcache_pkg::data_w-1:0] load_data
);

    logic [2*dcache_pkg::data_w-1:0] window;
    logic [2*dcache_pkg::data_w-1:0] shifted;

    // little-endian window with the lower address in the low half
    assign window  = {second_word, first_word};
    assign shifted = window >> {lookup_addr[dcache_pkg::offset_w-1:0], 3'b000};

    always_comb begin
        case (size)
            dcache_pkg::size_byte: begin
                load_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            dcache_pkg::size_half: begin
                load_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            dcache_pkg::size_word: begin
                load_data = shifted[dcache_pkg::data_w-1:0];
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    always_comb begin
        if (!$isunknown(size)) begin
            assert (size != 2'b11)
                else $error("load_align: unused size code");
        end
    end

endmodule

/* hdl/line_store.sv */
// line store holding valid, tag and data arrays with two-line lookup, refill and store merge
`timescale 1ns/1ps

module line_store (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [dcache_pkg::addr_w-1:0] lookup_addr,
    output dcache_pkg::line_span_t        span,
    output logic [dcache_pkg::data_w-1:0] first_word,
    output logic [dcache_pkg::data_w-1:0] second_word,
    input  logic                          fill_en,
    input  logic [dcache_pkg::addr_w-1:0] fill_addr,
    input  logic [dcache_pkg::data_w-1:0] fill_data,
    input  logic                          store_en,
    input  dcache_pkg::access_size_e      store_size,
    input  logic [dcache_pkg::data_w-1:0] store_data
);

    logic [dcache_pkg::num_lines-1:0] valid;
    logic [dcache_pkg::tag_w-1:0]     tags  [dcache_pkg::num_lines];
    logic [dcache_pkg::data_w-1:0]    lines [dcache_pkg::num_lines];

    logic [dcache_pkg::addr_w-1:0]  next_addr;
    logic [dcache_pkg::tag_w-1:0]   first_tag;
    logic [dcache_pkg::tag_w-1:0]   second_tag;
    logic [dcache_pkg::tag_w-1:0]   fill_tag;
    logic [dcache_pkg::index_w-1:0] first_index;
    logic [dcache_pkg::index_w-1:0] second_index;
    logic [dcache_pkg::index_w-1:0] fill_index;
    dcache_pkg::store_lanes_t       lanes;

    // second line found from the next word's full address so a wrap bumps the tag
    assign next_addr = lookup_addr + dcache_pkg::word_step;

    assign first_tag    = lookup_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
    assign first_index  = lookup_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
    assign second_tag   = next_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
    assign second_index = next_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
    assign fill_tag     = fill_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
    assign fill_index   = fill_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];

    assign lanes = dcache_pkg::store_lanes(lookup_addr[dcache_pkg::offset_w-1:0],
                                           store_size, store_data);

    assign span.first_hit     = valid[first_index] && (tags[first_index] == first_tag);
    assign span.second_needed = |lanes.strobe[7:4];
    assign span.second_hit    = valid[second_index] && (tags[second_index] == second_tag);
    // spare bit
    assign span.second_index_wrapped = 1'b0;

    assign first_word  = lines[first_index];
    assign second_word = lines[second_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_index]  <= fill_tag;
            lines[fill_index] <= fill_data;
        end else if (store_en) begin
            // merge only into lines already present
            for (int b = 0; b < dcache_pkg::data_w / 8; b++) begin
                if (span.first_hit && lanes.strobe[b]) begin
                    lines[first_index][8*b +: 8] <= lanes.data[8*b +: 8];
                end
                if (span.second_hit && lanes.strobe[4+b]) begin
                    lines[second_index][8*b +: 8] <= lanes.data[dcache_pkg::data_w + 8*b +: 8];
                end
            end
        end
    end

    // refill and store merge come from different controller phases
    assert property (@(posedge clk) disable iff (reset) !(fill_en && store_en))
        else $error("line_store: fill and store in the same cycle");

endmodule

/* hdl/dcache_pkg.sv */
// data cache package: widths, access encodings, bus structs and store lane placement
package dcache_pkg;

    localparam int addr_w    = 20;
    localparam int data_w    = 32;
    localparam int offset_w  = 2;
    localparam int index_w   = 4;
    localparam int tag_w     = addr_w - index_w - offset_w;
    localparam int num_lines = 1 << index_w;

    // distance from one line to the next in bytes
    localparam logic [addr_w-1:0] word_step = addr_w'(data_w / 8);

    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } access_op_e;

    typedef struct packed {
        access_op_e          op;
        access_size_e        size;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
    } cache_req_t;

    // addr is always word aligned
    typedef struct packed {
        logic                write;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [3:0]          strobe;
    } mem_req_t;

    typedef struct packed {
        logic first_hit;
        logic second_needed;
        logic second_hit;
        logic second_index_wrapped;
    } line_span_t;

    // two adjacent words, lower address in the low half
    typedef struct packed {
        logic [2*data_w-1:0] data;
        logic [7:0]          strobe;
    } store_lanes_t;

    function automatic store_lanes_t store_lanes(
        input logic [offset_w-1:0] offset,
        input access_size_e        size,
        input logic [data_w-1:0]   wdata
    );
        store_lanes_t lanes;
        logic [3:0]   base;
        case (size)
            size_byte: base = 4'b0001;
            size_half: base = 4'b0011;
            size_word: base = 4'b1111;
            default:   base = 4'b0000;
        endcase
        lanes.data   = {{data_w{1'b0}}, wdata} << {offset, 3'b000};
        lanes.strobe = {4'b0000, base} << offset;
        return lanes;
    endfunction

endpackage
